// ==== axil_pkg.sv ====
// Bus widths, SRAM size and limits, slave wait count, prot and response codes, FSM states
`default_nettype none

package axil_pkg;

  // ------------------------------
  // Bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;  // One strobe per byte

  // ------------------------------
  // SRAM and slave timing
  localparam int MEM_WORDS = 256;      // 64-bit words
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam logic [ADDR_W-1:0] MEM_LIMIT = ADDR_W'(MEM_WORDS * 8);  // First byte out of range
  localparam int SLV_WAIT = 2;         // Cycles before each ready or response
  localparam int WAIT_W = $clog2(SLV_WAIT + 1);
  localparam logic [WAIT_W-1:0] WAIT_LOAD = WAIT_W'(SLV_WAIT - 1);

  // ------------------------------
  // AXI codes
  // Unprivileged, secure, data access
  localparam logic [2:0] AXI_PROT_DATA = 3'b000;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Master channel machines
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_DONE} rd_state_e;
  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_RESP, WR_DONE} wr_state_e;

endpackage

`default_nettype wire

// ==== rw_arbiter.sv ====
// Fixed-priority arbiter sharing one request port between load/store and fetch
`timescale 1ns/100ps
`default_nettype none

module rw_arbiter (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,
  // Fetch side
  input  wire                         i_if_valid,
  input  wire [axil_pkg::ADDR_W-1:0]  i_if_addr,
  output logic                        o_if_addr_ok,
  output logic                        o_if_data_ok,
  output logic [axil_pkg::DATA_W-1:0] o_if_rdata,
  output logic                        o_if_err,
  // Load/store side
  input  wire                         i_ls_valid,
  input  wire                         i_ls_wen,
  input  wire [axil_pkg::ADDR_W-1:0]  i_ls_addr,
  input  wire [axil_pkg::DATA_W-1:0]  i_ls_wdata,
  input  wire [axil_pkg::STRB_W-1:0]  i_ls_wstrb,
  output logic                        o_ls_addr_ok,
  output logic                        o_ls_data_ok,
  output logic [axil_pkg::DATA_W-1:0] o_ls_rdata,
  output logic                        o_ls_err,
  // Master side
  output logic                        o_req_valid,
  output logic                        o_req_wen,
  output logic [axil_pkg::ADDR_W-1:0] o_req_addr,
  output logic [axil_pkg::DATA_W-1:0] o_req_wdata,
  output logic [axil_pkg::STRB_W-1:0] o_req_wstrb,
  input  wire                         i_req_addr_ok,
  input  wire                         i_req_data_ok,
  input  wire [axil_pkg::DATA_W-1:0]  i_req_rdata,
  input  wire                         i_req_err
);

  logic busy;      // Request in flight, grant locked
  logic owner_ls;  // Load/store owns the grant
  logic sel_ls;

  // Load/store first when idle, locked owner otherwise
  assign sel_ls = busy ? owner_ls : i_ls_valid;

  // ------------------------------
  // Request mux
  assign o_req_valid = ~busy & (i_ls_valid | i_if_valid);
  assign o_req_wen   = sel_ls & i_ls_wen;  // Fetch is read only
  assign o_req_addr  = sel_ls ? i_ls_addr : i_if_addr;
  assign o_req_wdata = sel_ls ? i_ls_wdata : '0;
  assign o_req_wstrb = sel_ls ? i_ls_wstrb : '0;

  // ------------------------------
  // Response routing
  assign o_ls_addr_ok = i_req_addr_ok & sel_ls;
  assign o_if_addr_ok = i_req_addr_ok & ~sel_ls;
  assign o_ls_data_ok = i_req_data_ok & owner_ls;
  assign o_if_data_ok = i_req_data_ok & ~owner_ls;
  assign o_ls_rdata   = owner_ls ? i_req_rdata : '0;
  assign o_if_rdata   = owner_ls ? '0 : i_req_rdata;
  assign o_ls_err     = i_req_err & owner_ls;
  assign o_if_err     = i_req_err & ~owner_ls;

  // Grant lock from addr_ok to data_ok
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      owner_ls <= 1'b0;
    end else if (i_req_addr_ok) begin
      busy     <= 1'b1;
      owner_ls <= sel_ls;
    end else if (i_req_data_ok) begin
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== axil_master.sv ====
// AXI-lite master turning one accepted request into a single read or write transaction
`timescale 1ns/100ps
`default_nettype none

module axil_master (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,
  // Request port
  input  wire                         i_req_valid,
  input  wire                         i_req_wen,
  input  wire [axil_pkg::ADDR_W-1:0]  i_req_addr,
  input  wire [axil_pkg::DATA_W-1:0]  i_req_wdata,
  input  wire [axil_pkg::STRB_W-1:0]  i_req_wstrb,
  output logic                        o_req_addr_ok,
  output logic                        o_req_data_ok,
  output logic [axil_pkg::DATA_W-1:0] o_req_rdata,
  output logic                        o_req_err,
  // Write address
  output logic                        o_awvalid,
  input  wire                         i_awready,
  output logic [axil_pkg::ADDR_W-1:0] o_awaddr,
  output logic [2:0]                  o_awprot,
  // Write data
  output logic                        o_wvalid,
  input  wire                         i_wready,
  output logic [axil_pkg::DATA_W-1:0] o_wdata,
  output logic [axil_pkg::STRB_W-1:0] o_wstrb,
  // Write response
  input  wire                         i_bvalid,
  output logic                        o_bready,
  input  wire [1:0]                   i_bresp,
  // Read address
  output logic                        o_arvalid,
  input  wire                         i_arready,
  output logic [axil_pkg::ADDR_W-1:0] o_araddr,
  output logic [2:0]                  o_arprot,
  // Read data
  input  wire                         i_rvalid,
  output logic                        o_rready,
  input  wire [axil_pkg::DATA_W-1:0]  i_rdata,
  input  wire [1:0]                   i_rresp
);

  axil_pkg::rd_state_e rd_state;
  axil_pkg::wr_state_e wr_state;

  logic aw_pend, w_pend;  // Channel still waiting for its handshake
  logic aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic accept;

  logic [axil_pkg::ADDR_W-1:0] addr_q;
  logic [axil_pkg::DATA_W-1:0] wdata_q;
  logic [axil_pkg::STRB_W-1:0] wstrb_q;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid & i_wready;
  assign b_fire  = o_bready & i_bvalid;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = o_rready & i_rvalid;

  // One transaction at a time, both machines must be idle
  assign o_req_addr_ok = i_req_valid & (rd_state == axil_pkg::RD_IDLE)
                         & (wr_state == axil_pkg::WR_IDLE);
  assign accept        = o_req_addr_ok;
  assign o_req_data_ok = (rd_state == axil_pkg::RD_DONE) | (wr_state == axil_pkg::WR_DONE);

  // Request fields held stable for the channels
  always_ff @(posedge i_aclk) begin
    if (accept) begin
      addr_q  <= i_req_addr;
      wdata_q <= i_req_wdata;
      wstrb_q <= i_req_wstrb;
    end
  end

  // ------------------------------
  // Write machine
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state <= axil_pkg::WR_IDLE;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
    end else begin
      case (wr_state)
        axil_pkg::WR_IDLE: if (accept && i_req_wen) begin
          wr_state <= axil_pkg::WR_ADDR;
          aw_pend  <= 1'b1;
          w_pend   <= 1'b1;
        end
        axil_pkg::WR_ADDR: begin
          aw_pend <= aw_pend & ~aw_fire;
          w_pend  <= w_pend & ~w_fire;
          if ((!aw_pend || aw_fire) && (!w_pend || w_fire))
            wr_state <= axil_pkg::WR_RESP;  // bready from next cycle
        end
        axil_pkg::WR_RESP: if (b_fire) wr_state <= axil_pkg::WR_DONE;
        default:           wr_state <= axil_pkg::WR_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Read machine
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_state <= axil_pkg::RD_IDLE;
    end else begin
      case (rd_state)
        axil_pkg::RD_IDLE: if (accept && !i_req_wen) rd_state <= axil_pkg::RD_ADDR;
        axil_pkg::RD_ADDR: if (ar_fire) rd_state <= axil_pkg::RD_DATA;
        axil_pkg::RD_DATA: if (r_fire) rd_state <= axil_pkg::RD_DONE;
        default:           rd_state <= axil_pkg::RD_IDLE;
      endcase
    end
  end

  // Completion data, shown with data_ok
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_req_err <= 1'b0;
    end else if (r_fire) begin
      o_req_err <= (i_rresp != axil_pkg::RESP_OKAY);
    end else if (b_fire) begin
      o_req_err <= (i_bresp != axil_pkg::RESP_OKAY);
    end
  end

  always_ff @(posedge i_aclk) begin
    if (r_fire) o_req_rdata <= i_rdata;  // Held until the next read
  end

  // ------------------------------
  // Channel outputs
  assign o_awvalid = (wr_state == axil_pkg::WR_ADDR) & aw_pend;
  assign o_wvalid  = (wr_state == axil_pkg::WR_ADDR) & w_pend;
  assign o_bready  = (wr_state == axil_pkg::WR_RESP);
  assign o_arvalid = (rd_state == axil_pkg::RD_ADDR);
  assign o_rready  = (rd_state == axil_pkg::RD_DATA);
  assign o_awaddr  = addr_q;
  assign o_araddr  = addr_q;
  assign o_wdata   = wdata_q;
  assign o_wstrb   = wstrb_q;
  assign o_awprot  = axil_pkg::AXI_PROT_DATA;
  assign o_arprot  = axil_pkg::AXI_PROT_DATA;

endmodule

`default_nettype wire

// ==== axil_sram_slave.sv ====
// AXI-lite slave over a word-addressed SRAM with byte strobes, wait states and range check
`timescale 1ns/100ps
`default_nettype none

module axil_sram_slave (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,
  // Write address
  input  wire                         i_awvalid,
  output logic                        o_awready,
  input  wire [axil_pkg::ADDR_W-1:0]  i_awaddr,
  input  wire [2:0]                   i_awprot,  // Not checked
  // Write data
  input  wire                         i_wvalid,
  output logic                        o_wready,
  input  wire [axil_pkg::DATA_W-1:0]  i_wdata,
  input  wire [axil_pkg::STRB_W-1:0]  i_wstrb,
  // Write response
  output logic                        o_bvalid,
  input  wire                         i_bready,
  output logic [1:0]                  o_bresp,
  // Read address
  input  wire                         i_arvalid,
  output logic                        o_arready,
  input  wire [axil_pkg::ADDR_W-1:0]  i_araddr,
  input  wire [2:0]                   i_arprot,  // Not checked
  // Read data
  output logic                        o_rvalid,
  input  wire                         i_rready,
  output logic [axil_pkg::DATA_W-1:0] o_rdata,
  output logic [1:0]                  o_rresp
);

  typedef enum logic [2:0] {S_IDLE, S_WR, S_B, S_AR, S_R} state_e;

  state_e state;
  logic [axil_pkg::WAIT_W-1:0] cnt;  // Wait countdown, zero means ready
  logic [axil_pkg::DATA_W-1:0] mem [axil_pkg::MEM_WORDS];

  logic wr_fire, rd_fire;
  logic wr_in_range, rd_in_range;
  logic [axil_pkg::MEM_IDX_W-1:0] wr_idx, rd_idx;

  assign wr_in_range = (i_awaddr < axil_pkg::MEM_LIMIT);
  assign rd_in_range = (i_araddr < axil_pkg::MEM_LIMIT);
  assign wr_idx      = i_awaddr[3 +: axil_pkg::MEM_IDX_W];
  assign rd_idx      = i_araddr[3 +: axil_pkg::MEM_IDX_W];

  // AW and W are taken together
  assign o_awready = (state == S_WR) && (cnt == '0);
  assign o_wready  = o_awready;
  assign o_bvalid  = (state == S_B) && (cnt == '0);
  assign o_arready = (state == S_AR) && (cnt == '0);
  assign o_rvalid  = (state == S_R) && (cnt == '0);

  assign wr_fire = o_awready & i_awvalid & i_wvalid;
  assign rd_fire = o_arready & i_arvalid;

  // ------------------------------
  // Channel sequencing
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= S_IDLE;
      cnt     <= '0;
      o_bresp <= axil_pkg::RESP_OKAY;
      o_rresp <= axil_pkg::RESP_OKAY;
    end else begin
      if (cnt != '0) cnt <= cnt - 1'b1;
      case (state)
        S_IDLE: begin
          if (i_awvalid && i_wvalid) begin  // Writes before reads
            state <= S_WR;
            cnt   <= axil_pkg::WAIT_LOAD;
          end else if (i_arvalid) begin
            state <= S_AR;
            cnt   <= axil_pkg::WAIT_LOAD;
          end
        end
        S_WR: if (wr_fire) begin
          state   <= S_B;
          cnt     <= axil_pkg::WAIT_LOAD;
          o_bresp <= wr_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
        S_B: if (o_bvalid && i_bready) state <= S_IDLE;
        S_AR: if (rd_fire) begin
          state   <= S_R;
          cnt     <= axil_pkg::WAIT_LOAD;
          o_rresp <= rd_in_range ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
        end
        S_R: if (o_rvalid && i_rready) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Read word captured at the AR handshake
  always_ff @(posedge i_aclk) begin
    if (rd_fire) begin
      o_rdata <= rd_in_range ? mem[rd_idx] : '0;
    end
  end

  // ------------------------------
  // SRAM, cleared on reset, byte merge on write
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < axil_pkg::MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_fire && wr_in_range) begin
      for (int b = 0; b < axil_pkg::STRB_W; b++) begin
        if (i_wstrb[b]) mem[wr_idx][8*b +: 8] <= i_wdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== axil_mem_subsys.sv ====
// Memory path top level joining the arbiter, AXI-lite master and SRAM slave
`timescale 1ns/100ps
`default_nettype none

module axil_mem_subsys (
  input  wire                         i_aclk,
  input  wire                         i_rst_n,
  // Fetch requester
  input  wire                         i_if_valid,
  input  wire [axil_pkg::ADDR_W-1:0]  i_if_addr,
  output logic                        o_if_addr_ok,
  output logic                        o_if_data_ok,
  output logic [axil_pkg::DATA_W-1:0] o_if_rdata,
  output logic                        o_if_err,
  // Load/store requester
  input  wire                         i_ls_valid,
  input  wire                         i_ls_wen,
  input  wire [axil_pkg::ADDR_W-1:0]  i_ls_addr,
  input  wire [axil_pkg::DATA_W-1:0]  i_ls_wdata,
  input  wire [axil_pkg::STRB_W-1:0]  i_ls_wstrb,
  output logic                        o_ls_addr_ok,
  output logic                        o_ls_data_ok,
  output logic [axil_pkg::DATA_W-1:0] o_ls_rdata,
  output logic                        o_ls_err
);

  // ------------------------------
  // Arbiter to master
  logic                        req_valid, req_wen, req_addr_ok, req_data_ok, req_err;
  logic [axil_pkg::ADDR_W-1:0] req_addr;
  logic [axil_pkg::DATA_W-1:0] req_wdata, req_rdata;
  logic [axil_pkg::STRB_W-1:0] req_wstrb;

  // Master to slave
  logic                        awvalid, awready, wvalid, wready, bvalid, bready;
  logic                        arvalid, arready, rvalid, rready;
  logic [axil_pkg::ADDR_W-1:0] awaddr, araddr;
  logic [2:0]                  awprot, arprot;
  logic [axil_pkg::DATA_W-1:0] wdata, rdata;
  logic [axil_pkg::STRB_W-1:0] wstrb;
  logic [1:0]                  bresp, rresp;

  rw_arbiter i_rw_arbiter (
    .i_aclk, .i_rst_n,
    .i_if_valid, .i_if_addr, .o_if_addr_ok, .o_if_data_ok, .o_if_rdata, .o_if_err,
    .i_ls_valid, .i_ls_wen, .i_ls_addr, .i_ls_wdata, .i_ls_wstrb,
    .o_ls_addr_ok, .o_ls_data_ok, .o_ls_rdata, .o_ls_err,
    .o_req_valid(req_valid), .o_req_wen(req_wen), .o_req_addr(req_addr),
    .o_req_wdata(req_wdata), .o_req_wstrb(req_wstrb), .i_req_addr_ok(req_addr_ok),
    .i_req_data_ok(req_data_ok), .i_req_rdata(req_rdata), .i_req_err(req_err)
  );

  axil_master i_axil_master (
    .i_aclk, .i_rst_n,
    .i_req_valid(req_valid), .i_req_wen(req_wen), .i_req_addr(req_addr),
    .i_req_wdata(req_wdata), .i_req_wstrb(req_wstrb), .o_req_addr_ok(req_addr_ok),
    .o_req_data_ok(req_data_ok), .o_req_rdata(req_rdata), .o_req_err(req_err),
    .o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr), .o_awprot(awprot),
    .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
    .i_bvalid(bvalid), .o_bready(bready), .i_bresp(bresp),
    .o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr), .o_arprot(arprot),
    .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata), .i_rresp(rresp)
  );

  axil_sram_slave i_axil_sram_slave (
    .i_aclk, .i_rst_n,
    .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr), .i_awprot(awprot),
    .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
    .o_bvalid(bvalid), .i_bready(bready), .o_bresp(bresp),
    .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr), .i_arprot(arprot),
    .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata), .o_rresp(rresp)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock source and power-on reset
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic o_aclk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD = 20;  // 40 ns clock
  localparam int RST_CYCLES  = 4;

  initial begin
    o_aclk = 1'b0;
    forever #HALF_PERIOD o_aclk = ~o_aclk;
  end

  // Release just after an edge, like the other inputs
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_aclk);
    #2 o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== axil_master_checker.sv ====
// AXI-lite channel assertions for the master, and the bind that attaches them
`timescale 1ns/100ps
`default_nettype none

module axil_master_checker (
  input wire                        i_aclk,
  input wire                        i_rst_n,
  input wire                        i_awvalid,
  input wire                        i_awready,
  input wire [axil_pkg::ADDR_W-1:0] i_awaddr,
  input wire                        i_wvalid,
  input wire                        i_wready,
  input wire [axil_pkg::DATA_W-1:0] i_wdata,
  input wire [axil_pkg::STRB_W-1:0] i_wstrb,
  input wire                        i_bvalid,
  input wire                        i_bready,
  input wire                        i_arvalid,
  input wire                        i_arready,
  input wire [axil_pkg::ADDR_W-1:0] i_araddr,
  input wire                        i_rvalid,
  input wire                        i_rready,
  input wire                        i_data_ok,
  input var axil_pkg::rd_state_e    i_rd_state,
  input var axil_pkg::wr_state_e    i_wr_state
);

  int unsigned fail_cnt = 0;  // Failed assertions so far

  // ------------------------------
  // Valid held, fields stable until ready
  a_aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
    else begin
      $error("AW valid dropped or address moved before ready");
      fail_cnt++;
    end

  a_w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
    else begin
      $error("W valid dropped or data moved before ready");
      fail_cnt++;
    end

  a_ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else begin
      $error("AR valid dropped or address moved before ready");
      fail_cnt++;
    end

  a_b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_bvalid && !i_bready |=> i_bvalid)
    else begin
      $error("B valid dropped before ready");
      fail_cnt++;
    end

  a_r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_rvalid && !i_rready |=> i_rvalid)
    else begin
      $error("R valid dropped before ready");
      fail_cnt++;
    end

  // ------------------------------
  a_done_pulse: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    i_data_ok |=> !i_data_ok)
    else begin
      $error("data_ok longer than one cycle");
      fail_cnt++;
    end

  // Slave responds only on the channel the master waits on
  a_resp_expected: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(i_bvalid && i_wr_state != axil_pkg::WR_RESP)
    && !(i_rvalid && i_rd_state != axil_pkg::RD_DATA))
    else begin
      $error("response valid with no matching request in flight");
      fail_cnt++;
    end

endmodule

bind axil_master axil_master_checker i_axil_master_checker (
  .i_aclk(i_aclk), .i_rst_n(i_rst_n),
  .i_awvalid(o_awvalid), .i_awready(i_awready), .i_awaddr(o_awaddr),
  .i_wvalid(o_wvalid), .i_wready(i_wready), .i_wdata(o_wdata), .i_wstrb(o_wstrb),
  .i_bvalid(i_bvalid), .i_bready(o_bready),
  .i_arvalid(o_arvalid), .i_arready(i_arready), .i_araddr(o_araddr),
  .i_rvalid(i_rvalid), .i_rready(o_rready), .i_data_ok(o_req_data_ok),
  .i_rd_state(rd_state), .i_wr_state(wr_state)
);

`default_nettype wire

// ==== tb_axil_mem_subsys.sv ====
// Testbench top with LFSR stimulus, reference memory model, checks and closing report
`timescale 1ns/100ps
`default_nettype none

module tb_axil_mem_subsys;

  localparam int N_LS = 200;
  localparam int N_IF = 200;
  localparam int TIMEOUT_CYCLES = (N_LS + N_IF) * 40;
  localparam logic [31:0] ADDR_LIMIT = axil_pkg::MEM_WORDS * 8;  // First byte out of range

  wire aclk;
  wire rst_n;

  logic                        i_if_valid, i_ls_valid, i_ls_wen;
  logic [axil_pkg::ADDR_W-1:0] i_if_addr, i_ls_addr;
  logic [axil_pkg::DATA_W-1:0] i_ls_wdata;
  logic [axil_pkg::STRB_W-1:0] i_ls_wstrb;
  wire                         o_if_addr_ok, o_if_data_ok, o_if_err;
  wire                         o_ls_addr_ok, o_ls_data_ok, o_ls_err;
  wire  [axil_pkg::DATA_W-1:0] o_if_rdata, o_ls_rdata;

  logic [axil_pkg::DATA_W-1:0] model_mem [axil_pkg::MEM_WORDS];
  logic [15:0] lfsr_state;
  int mismatch_errs = 0;
  int proto_errs    = 0;
  int assert_errs   = 0;
  int ls_done       = 0;
  int if_done       = 0;
  int cycles        = 0;

  // Pre-built request lists
  logic [1:0]                  ls_gap [N_LS];
  logic                        ls_wen [N_LS];
  logic [axil_pkg::ADDR_W-1:0] ls_addr [N_LS];
  logic [axil_pkg::DATA_W-1:0] ls_wdata [N_LS];
  logic [axil_pkg::STRB_W-1:0] ls_wstrb [N_LS];
  logic [1:0]                  if_gap [N_IF];
  logic [axil_pkg::ADDR_W-1:0] if_addr [N_IF];

  tb_clk_gen i_tb_clk_gen (.o_aclk(aclk), .o_rst_n(rst_n));

  axil_mem_subsys i_axil_mem_subsys (
    .i_aclk(aclk), .i_rst_n(rst_n),
    .i_if_valid, .i_if_addr, .o_if_addr_ok, .o_if_data_ok, .o_if_rdata, .o_if_err,
    .i_ls_valid, .i_ls_wen, .i_ls_addr, .i_ls_wdata, .i_ls_wstrb,
    .o_ls_addr_ok, .o_ls_data_ok, .o_ls_rdata, .o_ls_err
  );

  // ------------------------------
  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  // About 90 percent in range, out of range aliases the same words
  function automatic logic [31:0] pick_addr();
    logic [6:0] r;
    logic [31:0] base;
    r = 7'(take_bits(7));
    base = take_bits(6) << 3;
    return (r < 7'd115) ? base : ADDR_LIMIT + base;
  endfunction

  task automatic make_stimulus();
    logic [31:0] hi;
    logic [31:0] last_wr;
    logic [1:0] kind;
    logic have_wr;
    have_wr = 1'b0;
    last_wr = '0;
    for (int n = 0; n < N_LS; n++) begin
      hi = take_bits(3);
      ls_gap[n] = (n == 0 || hi[2]) ? 2'd0 : hi[1:0];  // First one collides with fetch
      kind = 2'(take_bits(2));
      ls_wen[n] = (kind < 2'd2);
      ls_addr[n] = pick_addr();
      if (kind == 2'd3 && have_wr) ls_addr[n] = last_wr;  // Read back a written word
      hi = take_bits(32);
      ls_wdata[n] = {hi, take_bits(32)};
      ls_wstrb[n] = 8'(take_bits(8));
      if (ls_wen[n]) begin
        last_wr = ls_addr[n];
        have_wr = 1'b1;
      end
    end
    for (int n = 0; n < N_IF; n++) begin
      hi = take_bits(3);
      if_gap[n] = (n == 0 || hi[2]) ? 2'd0 : hi[1:0];
      if_addr[n] = pick_addr();
    end
  endtask

  // ------------------------------
  // Load/store requester, drives 2 ns after the edge, samples on the falling edge
  task automatic run_ls();
    logic [axil_pkg::ADDR_W-1:0] a;
    logic [axil_pkg::MEM_IDX_W-1:0] idx;
    logic [axil_pkg::DATA_W-1:0] exp;
    logic hit, in_rng;
    for (int n = 0; n < N_LS; n++) begin
      repeat (ls_gap[n]) begin
        @(posedge aclk);
        #2;
      end
      a = ls_addr[n];
      i_ls_valid = 1'b1;
      i_ls_wen   = ls_wen[n];
      i_ls_addr  = a;
      i_ls_wdata = ls_wdata[n];
      i_ls_wstrb = ls_wstrb[n];
      hit = 1'b0;
      while (!hit) begin
        @(negedge aclk);
        hit = o_ls_addr_ok;
        @(posedge aclk);
        #2;
      end
      i_ls_valid = 1'b0;
      hit = 1'b0;
      while (!hit) begin
        @(negedge aclk);
        hit = o_ls_data_ok;
        if (!hit) begin
          @(posedge aclk);
          #2;
        end
      end
      in_rng = (a < ADDR_LIMIT);
      idx = a[3 +: axil_pkg::MEM_IDX_W];
      if (o_ls_err !== !in_rng) begin
        $display("mismatch o_ls_err addr 0x%h: got 0x%h expected 0x%h", a, o_ls_err, !in_rng);
        mismatch_errs++;
      end
      if (!ls_wen[n]) begin
        exp = in_rng ? model_mem[idx] : '0;
        if (o_ls_rdata !== exp) begin
          $display("mismatch o_ls_rdata addr 0x%h: got 0x%h expected 0x%h", a, o_ls_rdata, exp);
          mismatch_errs++;
        end
      end else if (in_rng) begin
        for (int b = 0; b < axil_pkg::STRB_W; b++) begin
          if (ls_wstrb[n][b]) model_mem[idx][8*b +: 8] = ls_wdata[n][8*b +: 8];
        end
      end
      @(posedge aclk);
      #2;
    end
  endtask

  // Fetch requester, reads only
  task automatic run_if();
    logic [axil_pkg::ADDR_W-1:0] a;
    logic [axil_pkg::DATA_W-1:0] exp;
    logic hit, in_rng;
    for (int n = 0; n < N_IF; n++) begin
      repeat (if_gap[n]) begin
        @(posedge aclk);
        #2;
      end
      a = if_addr[n];
      i_if_valid = 1'b1;
      i_if_addr  = a;
      hit = 1'b0;
      while (!hit) begin
        @(negedge aclk);
        hit = o_if_addr_ok;
        @(posedge aclk);
        #2;
      end
      i_if_valid = 1'b0;
      hit = 1'b0;
      while (!hit) begin
        @(negedge aclk);
        hit = o_if_data_ok;
        if (!hit) begin
          @(posedge aclk);
          #2;
        end
      end
      in_rng = (a < ADDR_LIMIT);
      exp = in_rng ? model_mem[a[3 +: axil_pkg::MEM_IDX_W]] : '0;
      if (o_if_err !== !in_rng) begin
        $display("mismatch o_if_err addr 0x%h: got 0x%h expected 0x%h", a, o_if_err, !in_rng);
        mismatch_errs++;
      end
      if (o_if_rdata !== exp) begin
        $display("mismatch o_if_rdata addr 0x%h: got 0x%h expected 0x%h", a, o_if_rdata, exp);
        mismatch_errs++;
      end
      @(posedge aclk);
      #2;
    end
  endtask

  // ------------------------------
  // Grant order and data_ok counting
  always @(negedge aclk) begin
    if (rst_n) begin
      if (o_ls_data_ok) ls_done++;
      if (o_if_data_ok) if_done++;
      if (o_if_addr_ok && i_ls_valid) begin
        $display("fetch was accepted while load/store was also requesting");
        proto_errs++;
      end
      if ((o_if_addr_ok && !i_if_valid) || (o_ls_addr_ok && !i_ls_valid)) begin
        $display("addr_ok was raised for a side with no request");
        proto_errs++;
      end
    end
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("stall: no finish after %0d cycles, load/store %0d of %0d, fetch %0d of %0d done",
               cycles, ls_done, N_LS, if_done, N_IF);
      $display("errors: %0d mismatch, %0d protocol, %0d assertion",
               mismatch_errs, proto_errs + 1,
               i_axil_mem_subsys.i_axil_master.i_axil_master_checker.fail_cnt);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    i_if_valid = 1'b0;
    i_if_addr  = '0;
    i_ls_valid = 1'b0;
    i_ls_wen   = 1'b0;
    i_ls_addr  = '0;
    i_ls_wdata = '0;
    i_ls_wstrb = '0;
    lfsr_state = 16'd48479;
    for (int i = 0; i < axil_pkg::MEM_WORDS; i++) model_mem[i] = '0;
    make_stimulus();
    wait (rst_n === 1'b1);
    // Quiet outputs with no request pending
    repeat (4) begin
      @(negedge aclk);
      if (o_ls_addr_ok || o_if_addr_ok || o_ls_data_ok || o_if_data_ok) begin
        $display("addr_ok or data_ok went high after reset with no request");
        proto_errs++;
      end
    end
    @(posedge aclk);
    #2;
    fork
      run_ls();
      run_if();
    join
    repeat (4) @(posedge aclk);
    if (ls_done != N_LS || if_done != N_IF) begin
      $display("data_ok count wrong, load/store saw %0d for %0d requests, fetch %0d for %0d",
               ls_done, N_LS, if_done, N_IF);
      proto_errs++;
    end
    assert_errs = i_axil_mem_subsys.i_axil_master.i_axil_master_checker.fail_cnt;
    $display("errors: %0d mismatch, %0d protocol, %0d assertion",
             mismatch_errs, proto_errs, assert_errs);
    if (mismatch_errs == 0 && proto_errs == 0 && assert_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
axil_pkg.sv
rw_arbiter.sv
axil_master.sv
axil_sram_slave.sv
axil_mem_subsys.sv
tb_clk_gen.sv
axil_master_checker.sv
tb_axil_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: axil_mem_subsys

sources:
  - axil_pkg.sv
  - rw_arbiter.sv
  - axil_master.sv
  - axil_sram_slave.sv
  - axil_mem_subsys.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - axil_master_checker.sv
      - tb_axil_mem_subsys.sv
